/* rv_decode.f */
hw/rv_decode_pkg.sv
hw/id_decoder.sv
hw/id_imm_gen.sv
hw/id_operand_sel.sv
hw/id_jump_target.sv
hw/id_ex_reg.sv
hw/id_stage.sv
verif/tb_id_stage.sv

/* Bender.yml */
package:
  name: rv_decode

sources:
  # RTL in dependency order
  - hw/rv_decode_pkg.sv
  - hw/id_decoder.sv
  - hw/id_imm_gen.sv
  - hw/id_operand_sel.sv
  - hw/id_jump_target.sv
  - hw/id_ex_reg.sv
  - hw/id_stage.sv
  - target: test
    files:
      - verif/tb_id_stage.sv

/* verif/tb_id_stage.sv */
// Self-checking testbench for the RV32I decode stage
// Random instructions, forwarding and back-pressure against a reference decode
module tb_id_stage;
  timeunit 1ns;
  timeprecision 100ps;

  import rv_decode_pkg::*;

  localparam int unsigned NUM_INSTR    = 2000;
  localparam int unsigned ACCEPT_LIMIT = 200;
  localparam int unsigned DRAIN_LIMIT  = 50;
  // Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS    = 32'h80200003;

  logic      clk = 1'b0;
  logic      rst_n;
  if_id_t    if_id_i;
  logic      if_valid_i;
  logic      id_ready_o;
  byp_sel_t  byp_sel_i;
  xlen_t     rf_rdata_a_i;
  xlen_t     rf_rdata_b_i;
  xlen_t     ex_result_i;
  xlen_t     wb_result_i;
  reg_addr_t rf_raddr_a_o;
  reg_addr_t rf_raddr_b_o;
  xlen_t     jmp_target_o;
  id_ex_t    id_ex_o;
  logic      ex_valid_o;
  logic      ex_ready_i;

  logic [31:0] lfsr_state  = 32'h5bf32479;
  id_ex_t      expected_q[$];
  // Output valid predicted from the handshake rules
  logic        exp_valid   = 1'b0;
  logic        hold_active = 1'b0;
  id_ex_t      held_rec;

  always #2 clk = ~clk;

  id_stage dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .if_id_i      (if_id_i),
    .if_valid_i   (if_valid_i),
    .id_ready_o   (id_ready_o),
    .byp_sel_i    (byp_sel_i),
    .rf_rdata_a_i (rf_rdata_a_i),
    .rf_rdata_b_i (rf_rdata_b_i),
    .ex_result_i  (ex_result_i),
    .wb_result_i  (wb_result_i),
    .rf_raddr_a_o (rf_raddr_a_o),
    .rf_raddr_b_o (rf_raddr_b_o),
    .jmp_target_o (jmp_target_o),
    .id_ex_o      (id_ex_o),
    .ex_valid_o   (ex_valid_o),
    .ex_ready_i   (ex_ready_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////////////////////

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned count);
    logic [31:0] value;
    logic        out_bit;
    int unsigned i;
    value = '0;
    for (i = 0; i < count; i++) begin
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
        lfsr_state = lfsr_state ^ LFSR_TAPS;
      end
      value = {value[30:0], out_bit};
    end
    return value;
  endfunction

  // EX ready three cycles in four
  function automatic logic ready_level();
    return rand_bits(2) != 0;
  endfunction

  function automatic fw_sel_e pick_fw();
    logic [31:0] value;
    value = rand_bits(2);
    case (value[1:0])
      2'd1:    return FW_EX;
      2'd2:    return FW_WB;
      default: return FW_REGFILE;
    endcase
  endfunction

  // Legal encodings of every class plus opcodes outside the 32-bit space
  function automatic logic [31:0] make_instr();
    logic [31:0] w;
    logic [2:0]  f3;
    int          kind;
    w    = rand_bits(32);
    kind = rand_bits(4) % 10;
    f3   = w[14:12];
    case (kind)
      0: begin
        w[6:0]   = OPC_OP;
        w[31:25] = (w[30] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0;
      end
      1: begin
        w[6:0] = OPC_OP_IMM;
        if (f3 == 3'b001) begin
          w[31:25] = 7'b0;
        end else if (f3 == 3'b101) begin
          w[31:25] = w[30] ? 7'b0100000 : 7'b0;
        end
      end
      2: w[6:0] = OPC_LUI;
      3: w[6:0] = OPC_AUIPC;
      4: w[6:0] = OPC_JAL;
      5: begin
        w[6:0]   = OPC_JALR;
        w[14:12] = 3'b000;
      end
      6: begin
        w[6:0] = OPC_BRANCH;
        // No compares at funct3 010 and 011
        if (f3[2:1] == 2'b01) begin
          w[14] = 1'b1;
        end
      end
      7: begin
        w[6:0] = OPC_LOAD;
        if (f3[1:0] == 2'b11) begin
          w[14:12] = 3'b010;
        end else if (f3 == 3'b110) begin
          w[14:12] = 3'b100;
        end
      end
      8: begin
        w[6:0] = OPC_STORE;
        w[14]  = 1'b0;
        if (f3[1:0] == 2'b11) begin
          w[13:12] = 2'b10;
        end
      end
      default: w[1] = 1'b0;
    endcase
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic xlen_t forward_value(input fw_sel_e sel, input xlen_t rf_data,
                                          input xlen_t ex_data, input xlen_t wb_data);
    if (sel == FW_EX) begin
      return ex_data;
    end
    if (sel == FW_WB) begin
      return wb_data;
    end
    return rf_data;
  endfunction

  // SUB and SRA only with the alternate funct7
  function automatic alu_op_e alu_for_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  function automatic id_ex_t build_expected(input if_id_t item, input byp_sel_t byp,
                                            input xlen_t rfa, input xlen_t rfb,
                                            input xlen_t exr, input xlen_t wbr);
    id_ex_t      rec;
    logic [31:0] w;
    logic [2:0]  f3;
    xlen_t       rs1_val;
    xlen_t       rs2_val;
    xlen_t       imm_i;
    xlen_t       imm_s;
    xlen_t       imm_b;
    xlen_t       imm_u;
    w       = item.instr;
    f3      = w[14:12];
    rs1_val = forward_value(byp.a_sel, rfa, exr, wbr);
    rs2_val = forward_value(byp.b_sel, rfb, exr, wbr);
    // Immediates from the RV32I encoding tables
    imm_i   = {{20{w[31]}}, w[31:20]};
    imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u   = {w[31:12], 12'b0};

    rec           = '0;
    rec.pc        = item.pc;
    rec.rf_waddr  = w[11:7];
    rec.alu_op    = ALU_ADD;
    rec.operand_a = rs1_val;
    rec.operand_b = rs2_val;
    case (w[6:0])
      OPC_OP: begin
        rec.rf_we  = 1'b1;
        rec.alu_op = alu_for_funct3(f3, w[30]);
      end
      OPC_OP_IMM: begin
        rec.rf_we     = 1'b1;
        rec.operand_b = imm_i;
        rec.alu_op    = alu_for_funct3(f3, (f3 == 3'b101) && w[30]);
      end
      OPC_LUI: begin
        rec.rf_we     = 1'b1;
        rec.operand_a = '0;
        rec.operand_b = imm_u;
      end
      OPC_AUIPC: begin
        rec.rf_we     = 1'b1;
        rec.operand_a = item.pc;
        rec.operand_b = imm_u;
      end
      OPC_JAL, OPC_JALR: begin
        rec.rf_we     = 1'b1;
        rec.jump      = 1'b1;
        rec.operand_a = item.pc;
        rec.operand_b = PC_INCR;
      end
      OPC_BRANCH: begin
        rec.branch    = 1'b1;
        rec.operand_c = item.pc + imm_b;
        case (f3)
          3'b000:  rec.alu_op = ALU_EQ;
          3'b001:  rec.alu_op = ALU_NE;
          3'b100:  rec.alu_op = ALU_LT;
          3'b101:  rec.alu_op = ALU_GE;
          3'b110:  rec.alu_op = ALU_LTU;
          default: rec.alu_op = ALU_GEU;
        endcase
      end
      OPC_LOAD, OPC_STORE: begin
        rec.lsu_en   = 1'b1;
        rec.lsu_size = (f3[1:0] == 2'b00) ? LSU_BYTE :
                       (f3[1:0] == 2'b01) ? LSU_HALF : LSU_WORD;
        if (w[6:0] == OPC_LOAD) begin
          rec.rf_we        = 1'b1;
          rec.operand_b    = imm_i;
          rec.lsu_sign_ext = !f3[2];
        end else begin
          // Store data rides in operand C
          rec.lsu_we    = 1'b1;
          rec.operand_b = imm_s;
          rec.operand_c = rs2_val;
        end
      end
      default: rec.illegal = 1'b1;
    endcase
    return rec;
  endfunction

  function automatic xlen_t jump_target_of(input if_id_t item, input xlen_t rs1_val);
    logic [31:0] w;
    xlen_t       imm_j;
    xlen_t       sum;
    w     = item.instr;
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    sum   = rs1_val + {{20{w[31]}}, w[31:20]};
    if (w[6:0] == OPC_JALR) begin
      return {sum[31:1], 1'b0};
    end
    return item.pc + imm_j;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [159:0] got,
                             input logic [159:0] exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("Verification failed");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("Verification failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic compare_record(input id_ex_t got, input id_ex_t exp);
    check_value("id_ex_o.pc", got.pc, exp.pc);
    check_value("id_ex_o.rf_waddr", got.rf_waddr, exp.rf_waddr);
    check_value("id_ex_o.rf_we", got.rf_we, exp.rf_we);
    check_value("id_ex_o.lsu_en", got.lsu_en, exp.lsu_en);
    check_value("id_ex_o.lsu_we", got.lsu_we, exp.lsu_we);
    check_value("id_ex_o.branch", got.branch, exp.branch);
    check_value("id_ex_o.jump", got.jump, exp.jump);
    check_value("id_ex_o.illegal", got.illegal, exp.illegal);
    // Datapath fields carry no meaning for an illegal instruction
    if (!exp.illegal) begin
      check_value("id_ex_o.alu_op", got.alu_op, exp.alu_op);
      check_value("id_ex_o.operand_a", got.operand_a, exp.operand_a);
      check_value("id_ex_o.operand_b", got.operand_b, exp.operand_b);
      check_value("id_ex_o.operand_c", got.operand_c, exp.operand_c);
    end
    if (exp.lsu_en) begin
      check_value("id_ex_o.lsu_size", got.lsu_size, exp.lsu_size);
      check_value("id_ex_o.lsu_sign_ext", got.lsu_sign_ext, exp.lsu_sign_ext);
    end
  endtask

  // Inputs and outputs are settled half a period after the driving edge
  always @(negedge clk) begin : monitor
    id_ex_t      exp_rec;
    xlen_t       rs1_val;
    logic [31:0] word;
    word = if_id_i.instr;
    if (!rst_n) begin
      check_value("ex_valid_o", ex_valid_o, 1'b0);
      check_value("id_ex_o control fields", {id_ex_o.rf_we, id_ex_o.lsu_en, id_ex_o.lsu_we,
                  id_ex_o.branch, id_ex_o.jump, id_ex_o.illegal}, '0);
      exp_valid   = 1'b0;
      hold_active = 1'b0;
    end else begin
      check_value("ex_valid_o", ex_valid_o, exp_valid);
      check_value("id_ready_o", id_ready_o, ex_ready_i);
      check_value("rf_raddr_a_o", rf_raddr_a_o, word[19:15]);
      check_value("rf_raddr_b_o", rf_raddr_b_o, word[24:20]);
      if (if_valid_i && (word[6:0] == OPC_JAL || word[6:0] == OPC_JALR)) begin
        rs1_val = forward_value(byp_sel_i.a_sel, rf_rdata_a_i, ex_result_i, wb_result_i);
        check_value("jmp_target_o", jmp_target_o, jump_target_of(if_id_i, rs1_val));
      end
      // Stalled output must not move
      if (hold_active) begin
        check_value("id_ex_o while stalled", id_ex_o, held_rec);
      end
      if (ex_valid_o && ex_ready_i) begin
        if (expected_q.size() == 0) begin
          abort_run("Record left id_ex_o with no accepted instruction behind it");
        end else begin
          exp_rec = expected_q.pop_front();
          compare_record(id_ex_o, exp_rec);
        end
      end
      if (if_valid_i && id_ready_o) begin
        expected_q.push_back(build_expected(if_id_i, byp_sel_i, rf_rdata_a_i,
                                            rf_rdata_b_i, ex_result_i, wb_result_i));
      end
      // State after the coming edge
      if (ex_ready_i) begin
        exp_valid = if_valid_i;
      end
      hold_active = !ex_ready_i;
      held_rec    = id_ex_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_instr();
    if_id_t   item;
    byp_sel_t byp;
    xlen_t    rfa;
    xlen_t    rfb;
    xlen_t    exr;
    xlen_t    wbr;
    int       cycles;
    logic     taken;
    item.instr = make_instr();
    item.pc    = rand_bits(30) << 2;
    byp.a_sel  = pick_fw();
    byp.b_sel  = pick_fw();
    rfa        = rand_bits(32);
    rfb        = rand_bits(32);
    exr        = rand_bits(32);
    wbr        = rand_bits(32);
    // Occasional fetch bubble
    if (rand_bits(3) == 0) begin
      @(posedge clk);
      if_valid_i <= 1'b0;
      ex_ready_i <= ready_level();
    end
    taken  = 1'b0;
    cycles = 0;
    while (!taken) begin
      if (cycles == ACCEPT_LIMIT) begin
        abort_run("Timeout: id_ready_o never accepted the pending instruction");
      end
      @(posedge clk);
      if_id_i      <= item;
      if_valid_i   <= 1'b1;
      byp_sel_i    <= byp;
      rf_rdata_a_i <= rfa;
      rf_rdata_b_i <= rfb;
      ex_result_i  <= exr;
      wb_result_i  <= wbr;
      ex_ready_i   <= ready_level();
      @(negedge clk);
      taken = id_ready_o;
      cycles++;
    end
  endtask

  initial begin : stimulus
    int n;
    int cycles;
    rst_n        = 1'b0;
    if_id_i      = '0;
    if_valid_i   = 1'b0;
    byp_sel_i    = '0;
    rf_rdata_a_i = '0;
    rf_rdata_b_i = '0;
    ex_result_i  = '0;
    wb_result_i  = '0;
    ex_ready_i   = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    for (n = 0; n < NUM_INSTR; n++) begin
      send_instr();
    end

    // Let the last record drain
    @(posedge clk);
    if_valid_i <= 1'b0;
    ex_ready_i <= 1'b1;
    cycles = 0;
    while (expected_q.size() != 0 && cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      cycles++;
    end

    if (expected_q.size() == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Verification failed");
      $fatal(1, "Timeout: %0d accepted instructions never left id_ex_o", expected_q.size());
    end
  end

endmodule

/* hw/id_stage.sv */
// RV32I instruction decode stage
// Decoder plus immediate, operand, target and ID/EX register blocks
module id_stage (
  input  logic                      clk,
  input  logic                      rst_n,
  input  rv_decode_pkg::if_id_t     if_id_i,
  input  logic                      if_valid_i,
  output logic                      id_ready_o,
  input  rv_decode_pkg::byp_sel_t   byp_sel_i,
  input  rv_decode_pkg::xlen_t      rf_rdata_a_i,
  input  rv_decode_pkg::xlen_t      rf_rdata_b_i,
  input  rv_decode_pkg::xlen_t      ex_result_i,
  input  rv_decode_pkg::xlen_t      wb_result_i,
  output rv_decode_pkg::reg_addr_t  rf_raddr_a_o,
  output rv_decode_pkg::reg_addr_t  rf_raddr_b_o,
  output rv_decode_pkg::xlen_t      jmp_target_o,
  output rv_decode_pkg::id_ex_t     id_ex_o,
  output logic                      ex_valid_o,
  input  logic                      ex_ready_i
);
  import rv_decode_pkg::*;

  dec_ctrl_t ctrl;
  xlen_t     imm_b;
  xlen_t     imm_i;
  xlen_t     imm_sb;
  xlen_t     imm_j;
  xlen_t     rs1_fw;
  xlen_t     branch_target;
  xlen_t     operand_a;
  xlen_t     operand_b;
  xlen_t     operand_c;

  // Register file read ports straight from the instruction
  assign rf_raddr_a_o = if_id_i.instr.r_fmt.rs1;
  assign rf_raddr_b_o = if_id_i.instr.r_fmt.rs2;

  // Single output slot, so ready follows EX
  assign id_ready_o = ex_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Decode and datapath
  ////////////////////////////////////////////////////////////////////////////

  id_decoder u_decoder (
    .instr_i (if_id_i.instr),
    .ctrl_o  (ctrl)
  );

  id_imm_gen u_imm_gen (
    .instr_i   (if_id_i.instr),
    .imm_sel_i (ctrl.imm_sel),
    .imm_b_o   (imm_b),
    .imm_i_o   (imm_i),
    .imm_sb_o  (imm_sb),
    .imm_j_o   (imm_j)
  );

  id_operand_sel u_operand_sel (
    .ctrl_i          (ctrl),
    .byp_sel_i       (byp_sel_i),
    .rf_rdata_a_i    (rf_rdata_a_i),
    .rf_rdata_b_i    (rf_rdata_b_i),
    .ex_result_i     (ex_result_i),
    .wb_result_i     (wb_result_i),
    .pc_i            (if_id_i.pc),
    .imm_b_i         (imm_b),
    .branch_target_i (branch_target),
    .rs1_fw_o        (rs1_fw),
    .operand_a_o     (operand_a),
    .operand_b_o     (operand_b),
    .operand_c_o     (operand_c)
  );

  // JALR uses the forwarded rs1
  id_jump_target u_jump_target (
    .jt_sel_i        (ctrl.jt_sel),
    .pc_i            (if_id_i.pc),
    .imm_j_i         (imm_j),
    .imm_i_i         (imm_i),
    .imm_sb_i        (imm_sb),
    .rs1_fw_i        (rs1_fw),
    .jmp_target_o    (jmp_target_o),
    .branch_target_o (branch_target)
  );

  id_ex_reg u_id_ex_reg (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     (if_valid_i),
    .ex_ready_i  (ex_ready_i),
    .ctrl_i      (ctrl),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .operand_c_i (operand_c),
    .pc_i        (if_id_i.pc),
    .rd_i        (if_id_i.instr.r_fmt.rd),
    .id_ex_o     (id_ex_o),
    .ex_valid_o  (ex_valid_o)
  );

endmodule

/* hw/id_ex_reg.sv */
// ID/EX pipeline register
// Valid/ready output stage holding one decoded record for execute
module id_ex_reg (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      valid_i,
  input  logic                      ex_ready_i,
  input  rv_decode_pkg::dec_ctrl_t  ctrl_i,
  input  rv_decode_pkg::xlen_t      operand_a_i,
  input  rv_decode_pkg::xlen_t      operand_b_i,
  input  rv_decode_pkg::xlen_t      operand_c_i,
  input  rv_decode_pkg::xlen_t      pc_i,
  input  rv_decode_pkg::reg_addr_t  rd_i,
  output rv_decode_pkg::id_ex_t     id_ex_o,
  output logic                      ex_valid_o
);
  import rv_decode_pkg::*;

  id_ex_t rec_d;

  // Record assembled from the decode outputs
  assign rec_d = '{
    alu_op:       ctrl_i.alu_op,
    operand_a:    operand_a_i,
    operand_b:    operand_b_i,
    operand_c:    operand_c_i,
    rf_we:        ctrl_i.rf_we,
    rf_waddr:     rd_i,
    lsu_en:       ctrl_i.lsu_en,
    lsu_we:       ctrl_i.lsu_we,
    lsu_size:     ctrl_i.lsu_size,
    lsu_sign_ext: ctrl_i.lsu_sign_ext,
    branch:       ctrl_i.branch,
    jump:         ctrl_i.jump,
    illegal:      ctrl_i.illegal,
    pc:           pc_i
  };

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_o    <= '0;
      ex_valid_o <= 1'b0;
    end else if (ex_ready_i) begin
      // EX consumes or is empty
      ex_valid_o <= valid_i;
      if (valid_i) begin
        id_ex_o <= rec_d;
      end
    end
  end

endmodule

/* hw/id_jump_target.sv */
// Jump and branch target adders
// JAL and JALR go out to fetch, the branch target travels to EX
module id_jump_target (
  input  rv_decode_pkg::jt_sel_e jt_sel_i,
  input  rv_decode_pkg::xlen_t   pc_i,
  input  rv_decode_pkg::xlen_t   imm_j_i,
  input  rv_decode_pkg::xlen_t   imm_i_i,
  input  rv_decode_pkg::xlen_t   imm_sb_i,
  input  rv_decode_pkg::xlen_t   rs1_fw_i,
  output rv_decode_pkg::xlen_t   jmp_target_o,
  output rv_decode_pkg::xlen_t   branch_target_o
);
  import rv_decode_pkg::*;

  xlen_t jal_target;
  xlen_t jalr_sum;

  assign jal_target = pc_i + imm_j_i;
  assign jalr_sum   = rs1_fw_i + imm_i_i;

  // JALR clears the low bit
  assign jmp_target_o = (jt_sel_i == JT_JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : jal_target;

  assign branch_target_o = pc_i + imm_sb_i;

endmodule

/* hw/id_operand_sel.sv */
// Operand selection
// Forwarding muxes for rs1 and rs2, then the A, B and C operand muxes
module id_operand_sel (
  input  rv_decode_pkg::dec_ctrl_t ctrl_i,
  input  rv_decode_pkg::byp_sel_t  byp_sel_i,
  input  rv_decode_pkg::xlen_t     rf_rdata_a_i,
  input  rv_decode_pkg::xlen_t     rf_rdata_b_i,
  input  rv_decode_pkg::xlen_t     ex_result_i,
  input  rv_decode_pkg::xlen_t     wb_result_i,
  input  rv_decode_pkg::xlen_t     pc_i,
  input  rv_decode_pkg::xlen_t     imm_b_i,
  input  rv_decode_pkg::xlen_t     branch_target_i,
  output rv_decode_pkg::xlen_t     rs1_fw_o,
  output rv_decode_pkg::xlen_t     operand_a_o,
  output rv_decode_pkg::xlen_t     operand_b_o,
  output rv_decode_pkg::xlen_t     operand_c_o
);
  import rv_decode_pkg::*;

  xlen_t rs2_fw;

  // Same mux for both sources
  function automatic xlen_t fw_mux(input fw_sel_e sel, input xlen_t rf_data,
                                   input xlen_t ex_data, input xlen_t wb_data);
    case (sel)
      FW_EX:   return ex_data;
      FW_WB:   return wb_data;
      default: return rf_data;
    endcase
  endfunction

  assign rs1_fw_o = fw_mux(byp_sel_i.a_sel, rf_rdata_a_i, ex_result_i, wb_result_i);
  assign rs2_fw   = fw_mux(byp_sel_i.b_sel, rf_rdata_b_i, ex_result_i, wb_result_i);

  ////////////////////////////////////////////////////////////////////////////
  // Operand muxes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl_i.op_a_sel)
      OP_A_PC:   operand_a_o = pc_i;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = rs1_fw_o;
    endcase
  end

  always_comb begin
    case (ctrl_i.op_b_sel)
      OP_B_IMM:    operand_b_o = imm_b_i;
      OP_B_PCINCR: operand_b_o = PC_INCR;
      default:     operand_b_o = rs2_fw;
    endcase
  end

  // Store data or branch target for EX
  always_comb begin
    case (ctrl_i.op_c_sel)
      OP_C_REG:    operand_c_o = rs2_fw;
      OP_C_BRANCH: operand_c_o = branch_target_i;
      default:     operand_c_o = '0;
    endcase
  end

endmodule

/* hw/id_imm_gen.sv */
// Immediate generator
// Builds the sign-extended RV32I immediates and picks the one for operand B
module id_imm_gen (
  input  rv_decode_pkg::instr_u   instr_i,
  input  rv_decode_pkg::imm_sel_e imm_sel_i,
  output rv_decode_pkg::xlen_t    imm_b_o,
  output rv_decode_pkg::xlen_t    imm_i_o,
  output rv_decode_pkg::xlen_t    imm_sb_o,
  output rv_decode_pkg::xlen_t    imm_j_o
);
  import rv_decode_pkg::*;

  xlen_t imm_s;
  xlen_t imm_u;
  logic  sign;

  // Sign always comes from bit 31
  assign sign = instr_i.r_fmt.funct7[6];

  assign imm_i_o = {{20{sign}}, instr_i.i_fmt.imm12};
  assign imm_s   = {{20{sign}}, instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};
  assign imm_u   = {instr_i.u_fmt.imm20, 12'b0};

  // B-type reuses the S fields with bit 7 moved up to bit 11
  assign imm_sb_o = {{20{sign}}, instr_i.s_fmt.imm_lo[0], instr_i.s_fmt.imm_hi[5:0],
                     instr_i.s_fmt.imm_lo[4:1], 1'b0};

  // J-type scrambles the U field
  assign imm_j_o = {{12{sign}}, instr_i.u_fmt.imm20[7:0], instr_i.u_fmt.imm20[8],
                    instr_i.u_fmt.imm20[18:9], 1'b0};

  always_comb begin
    case (imm_sel_i)
      IMM_S:   imm_b_o = imm_s;
      IMM_U:   imm_b_o = imm_u;
      IMM_B:   imm_b_o = imm_sb_o;
      IMM_J:   imm_b_o = imm_j_o;
      default: imm_b_o = imm_i_o;
    endcase
  end

endmodule

/* hw/id_decoder.sv */
// RV32I instruction decoder
// Maps opcode, funct3 and funct7 to operand selects and EX control fields
module id_decoder (
  input  rv_decode_pkg::instr_u    instr_i,
  output rv_decode_pkg::dec_ctrl_t ctrl_o
);
  import rv_decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;

  assign opcode  = instr_i.r_fmt.opcode;
  assign funct3  = instr_i.r_fmt.funct3;
  assign funct7  = instr_i.r_fmt.funct7;
  assign f7_zero = (funct7 == 7'b0000000);
  // SUB and SRA encoding
  assign f7_alt  = (funct7 == 7'b0100000);

  // Shared by OP and OP-IMM
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    // Defaults describe a register-register ADD with no side effects
    ctrl_o          = '0;
    ctrl_o.op_a_sel = OP_A_REG;
    ctrl_o.op_b_sel = OP_B_REG;
    ctrl_o.op_c_sel = OP_C_NONE;
    ctrl_o.imm_sel  = IMM_I;
    ctrl_o.jt_sel   = JT_JAL;
    ctrl_o.alu_op   = ALU_ADD;
    ctrl_o.lsu_size = LSU_WORD;

    case (opcode)
      OPC_OP: begin
        ctrl_o.rf_we  = 1'b1;
        ctrl_o.alu_op = arith_op(funct3, f7_alt);
        // Alternate funct7 only for SUB and SRA
        if (!(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
          ctrl_o.illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.alu_op   = arith_op(funct3, f7_alt && (funct3 == 3'b101));
        // Shift amount fits rs2 field, upper bits must be a valid funct7
        if ((funct3 == 3'b001 && !f7_zero) ||
            (funct3 == 3'b101 && !(f7_zero || f7_alt))) begin
          ctrl_o.illegal = 1'b1;
        end
      end
      OPC_LUI: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_ZERO;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_sel  = IMM_U;
      end
      OPC_AUIPC: begin
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.imm_sel  = IMM_U;
      end
      OPC_JAL, OPC_JALR: begin
        // Link value pc + 4 computed in EX
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.jump     = 1'b1;
        ctrl_o.op_a_sel = OP_A_PC;
        ctrl_o.op_b_sel = OP_B_PCINCR;
        ctrl_o.imm_sel  = (opcode == OPC_JAL) ? IMM_J : IMM_I;
        ctrl_o.jt_sel   = (opcode == OPC_JAL) ? JT_JAL : JT_JALR;
      end
      OPC_BRANCH: begin
        ctrl_o.branch   = 1'b1;
        ctrl_o.op_c_sel = OP_C_BRANCH;
        ctrl_o.imm_sel  = IMM_B;
        case (funct3)
          3'b000:  ctrl_o.alu_op = ALU_EQ;
          3'b001:  ctrl_o.alu_op = ALU_NE;
          3'b100:  ctrl_o.alu_op = ALU_LT;
          3'b101:  ctrl_o.alu_op = ALU_GE;
          3'b110:  ctrl_o.alu_op = ALU_LTU;
          3'b111:  ctrl_o.alu_op = ALU_GEU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        ctrl_o.rf_we        = 1'b1;
        ctrl_o.lsu_en       = 1'b1;
        ctrl_o.op_b_sel     = OP_B_IMM;
        ctrl_o.lsu_size     = lsu_size_e'(funct3[1:0]);
        ctrl_o.lsu_sign_ext = !funct3[2];
        // No LD and no LWU in RV32I
        ctrl_o.illegal      = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
      end
      OPC_STORE: begin
        ctrl_o.lsu_en   = 1'b1;
        ctrl_o.lsu_we   = 1'b1;
        ctrl_o.op_b_sel = OP_B_IMM;
        ctrl_o.op_c_sel = OP_C_REG;
        ctrl_o.imm_sel  = IMM_S;
        ctrl_o.lsu_size = lsu_size_e'(funct3[1:0]);
        ctrl_o.illegal  = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: begin
        ctrl_o.illegal = 1'b1;
      end
    endcase

    // Illegal instructions must not write or touch memory
    if (ctrl_o.illegal) begin
      ctrl_o.rf_we        = 1'b0;
      ctrl_o.lsu_en       = 1'b0;
      ctrl_o.lsu_we       = 1'b0;
      ctrl_o.lsu_size     = LSU_WORD;
      ctrl_o.lsu_sign_ext = 1'b0;
      ctrl_o.branch       = 1'b0;
      ctrl_o.jump         = 1'b0;
    end
  end

endmodule

/* hw/rv_decode_pkg.sv */
// RV32I decode stage shared definitions
// Widths, major opcodes, select encodings, instruction formats and
// the records passed between fetch, decode and execute
package rv_decode_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned XLEN       = 32;
  localparam int unsigned NUM_REGS   = 32;
  localparam int unsigned REG_ADDR_W = $clog2(NUM_REGS);

  // Major opcodes, bits [6:0] of the instruction
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // Link offset for JAL and JALR, no compressed support
  localparam logic [XLEN-1:0] PC_INCR = 32'd4;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction word views
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Also carries the B-type immediate bits
  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  // Also carries the J-type immediate bits
  typedef struct packed {
    logic [19:0] imm20;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
  } instr_u;

  ////////////////////////////////////////////////////////////////////////////
  // Select and control encodings
  ////////////////////////////////////////////////////////////////////////////

  // Arithmetic ops then branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO}     op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM, OP_B_PCINCR}  op_b_sel_e;
  typedef enum logic [1:0] {OP_C_REG, OP_C_BRANCH, OP_C_NONE} op_c_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_U, IMM_B, IMM_J} imm_sel_e;
  typedef enum logic       {JT_JAL, JT_JALR}                   jt_sel_e;
  typedef enum logic [1:0] {FW_REGFILE, FW_EX, FW_WB}          fw_sel_e;

  // Matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {LSU_BYTE, LSU_HALF, LSU_WORD} lsu_size_e;

  ////////////////////////////////////////////////////////////////////////////
  // Stage records
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    instr_u instr;
    xlen_t  pc;
  } if_id_t;

  typedef struct packed {
    fw_sel_e a_sel;
    fw_sel_e b_sel;
  } byp_sel_t;

  typedef struct packed {
    op_a_sel_e op_a_sel;
    op_b_sel_e op_b_sel;
    op_c_sel_e op_c_sel;
    imm_sel_e  imm_sel;
    jt_sel_e   jt_sel;
    alu_op_e   alu_op;
    logic      rf_we;
    logic      lsu_en;
    logic      lsu_we;
    lsu_size_e lsu_size;
    logic      lsu_sign_ext;
    logic      branch;
    logic      jump;
    logic      illegal;
  } dec_ctrl_t;

  typedef struct packed {
    alu_op_e   alu_op;
    xlen_t     operand_a;
    xlen_t     operand_b;
    xlen_t     operand_c;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      lsu_en;
    logic      lsu_we;
    lsu_size_e lsu_size;
    logic      lsu_sign_ext;
    logic      branch;
    logic      jump;
    logic      illegal;
    xlen_t     pc;
  } id_ex_t;

endpackage
